//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_vic_loader -Mdir obj_dir -f sources.f \
	&& ./obj_dir/Vtb_vic_loader > sim.log 2>&1 \
	|| echo "Build or simulation returned an error status"

cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "Simulation run is clean" \
	|| { echo "Simulation run did not pass"; exit 1; }

//--- source/image_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module image_loader (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire loader_pkg::dl_req_t dl_i,
	output loader_pkg::mem_wr_t      wr_o,
	output loader_pkg::ram_blk_t     cart_blk_o
);

	logic                  load_crt;
	logic                  load_ct;
	logic                  load_rom;
	logic                  dl_q;
	logic                  ct_start;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  cart_wr;
	logic                  rom_wr;
	logic [15:0]           ct_addr;
	loader_pkg::mem_addr_u cur_addr;
	loader_pkg::ram_blk_t  blk_hit;
	loader_pkg::ram_blk_t  cart_blk_q;
	logic                  wr_stb_q;
	loader_pkg::mem_addr_u wr_addr_q;
	logic [7:0]            wr_data_q;

	assign load_crt = (dl_i.idx == `LDR_IDX_CRT);
	assign load_ct  = (dl_i.idx == `LDR_IDX_CT);
	assign load_rom = (dl_i.idx == `LDR_IDX_ROM);
	assign ct_start = ~dl_q & dl_i.dl & load_ct;

	// Only CRT files carry a load address header
	assign hdr_lo  = dl_i.dl & load_crt & dl_i.wr & (dl_i.addr == 25'd0);
	assign hdr_hi  = dl_i.dl & load_crt & dl_i.wr & (dl_i.addr == 25'd1);
	assign cart_wr = dl_i.dl & (load_crt | load_ct) & dl_i.wr & ~hdr_lo & ~hdr_hi
		& (cur_addr.byte_addr < `LDR_CART_LIMIT);
	assign rom_wr  = dl_i.dl & load_rom & dl_i.wr
		& (dl_i.addr >= `LDR_ROM_LO) & (dl_i.addr < `LDR_ROM_HI);

	//////////////////////////////////////////////////
	// Start address and block decode
	//////////////////////////////////////////////////

	// Extension '2'..'9' or 'A'..'B' names the start block
	always_comb begin
		ct_addr = cur_addr.byte_addr;
		if (dl_i.ext >= "2" && dl_i.ext <= "9") begin
			ct_addr = {dl_i.ext[3:0], 12'h000};
		end else if (dl_i.ext >= "A" && dl_i.ext <= "B") begin
			ct_addr = {dl_i.ext[3:0] + 4'd9, 12'h000};
		end
	end

	// Block 4 is the character ROM area and has no expansion bit
	always_comb begin
		blk_hit = '0;
		case (cur_addr.blk_view.blk)
			3'd0: blk_hit[0] = 1'b1;
			3'd1: blk_hit[1] = 1'b1;
			3'd2: blk_hit[2] = 1'b1;
			3'd3: blk_hit[3] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: blk_hit = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q       <= 1'b0;
			wr_stb_q   <= 1'b0;
			cart_blk_q <= '0;
		end else begin
			dl_q     <= dl_i.dl;
			wr_stb_q <= cart_wr | rom_wr;
			if (cart_wr) begin
				cart_blk_q <= cart_blk_q | blk_hit;
			end
		end
	end

	// Running cartridge address and write payload
	always_ff @(posedge clk_sys) begin
		if (hdr_lo) begin
			cur_addr.byte_addr[7:0] <= dl_i.data;
		end
		if (hdr_hi) begin
			cur_addr.byte_addr[15:8] <= dl_i.data;
		end
		if (cart_wr) begin
			wr_addr_q           <= cur_addr;
			wr_data_q           <= dl_i.data;
			cur_addr.byte_addr  <= cur_addr.byte_addr + 16'd1;
		end else if (rom_wr) begin
			wr_addr_q.byte_addr <= dl_i.addr[15:0] + `LDR_ROM_OFFSET;
			wr_data_q           <= dl_i.data;
		end
		if (ct_start) begin
			cur_addr.byte_addr <= ct_addr;
		end
	end

	assign wr_o       = '{wr: wr_stb_q, addr: wr_addr_q, data: wr_data_q};
	assign cart_blk_o = cart_blk_q;

endmodule

`default_nettype wire

//--- source/loader_params.svh
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

//////////////////////////////////////////////////
// Download index codes
//////////////////////////////////////////////////

// Program file with two-byte load address
`define LDR_IDX_PRG      8'h01
// Cartridge image with two-byte load address
`define LDR_IDX_CRT      8'h41
// Cartridge image, start block from the file extension
`define LDR_IDX_CT       8'h81
// KERNAL ROM image
`define LDR_IDX_ROM      8'h06

//////////////////////////////////////////////////
// Address limits
//////////////////////////////////////////////////

// First address a program may not write
`define LDR_PRG_LIMIT    16'hA000
// First address a cartridge may not write
`define LDR_CART_LIMIT   16'hC000

// KERNAL window inside the ROM image, upper bound exclusive
`define LDR_ROM_LO       25'h0004000
`define LDR_ROM_HI       25'h0008000
// Moves image offsets $4000-$7FFF up to $C000-$FFFF
`define LDR_ROM_OFFSET   16'h8000

//////////////////////////////////////////////////
// BASIC pointer bytes
//////////////////////////////////////////////////

// Six pointer bytes starting here, lo/hi pairs
`define LDR_PTR_BASE     16'h002D
// Two more pointer bytes, lo then hi
`define LDR_PTR_END      16'h00AE

`endif

//--- source/loader_pkg.sv
`default_nettype none

package loader_pkg;

	//////////////////////////////////////////////////
	// Download port
	//////////////////////////////////////////////////

	// One sample of the host download port
	typedef struct packed {
		logic        dl;    // Download in progress
		logic [7:0]  idx;   // File type index
		logic        wr;    // Byte strobe
		logic [24:0] addr;  // Offset inside the file
		logic [7:0]  data;
		logic [7:0]  ext;   // Last character of the file name
	} dl_req_t;

	//////////////////////////////////////////////////
	// Emulated memory
	//////////////////////////////////////////////////

	// 8 KB block number and offset inside the block
	typedef struct packed {
		logic [2:0]  blk;
		logic [12:0] off;
	} blk_addr_t;

	// Same 16-bit address, as a byte address or as block plus offset
	typedef union packed {
		logic [15:0] byte_addr;
		blk_addr_t   blk_view;
	} mem_addr_u;

	// One byte write into the machine
	typedef struct packed {
		logic        wr;
		mem_addr_u   addr;
		logic [7:0]  data;
	} mem_wr_t;

	// Expansion blocks
	// Bit 0 is $0400, bits 1-3 are $2000/$4000/$6000, bit 4 is $A000
	typedef logic [4:0] ram_blk_t;

endpackage

`default_nettype wire

//--- source/memory_map_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module memory_map_ctrl (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire loader_pkg::mem_wr_t  prg_wr_i,
	input  wire loader_pkg::mem_wr_t  img_wr_i,
	input  wire loader_pkg::ram_blk_t cart_blk_i,
	input  wire logic                 extram1_i,
	input  wire logic [1:0]           extram2_sel_i,
	input  wire logic                 extram3_i,
	input  wire logic                 cart_writable_i,
	input  wire logic                 rom_std_sel_i,
	output loader_pkg::mem_wr_t       mem_wr_o,
	output loader_pkg::ram_blk_t      ram_ext_o,
	output loader_pkg::ram_blk_t      ram_ext_ro_o,
	output logic                      rom_std_o
);

	logic [2:0]            extram2_blk;
	loader_pkg::ram_blk_t  menu_blk;
	loader_pkg::ram_blk_t  ext_q;
	loader_pkg::ram_blk_t  ro_q;
	logic                  rom_std_q;
	logic                  wr_stb_q;
	loader_pkg::mem_addr_u wr_addr_q;
	logic [7:0]            wr_data_q;

	//////////////////////////////////////////////////
	// Expansion map
	//////////////////////////////////////////////////

	// Menu RAM 2 grows upward from $2000 one 8 KB block at a time
	always_comb begin
		case (extram2_sel_i)
			2'd0: extram2_blk = 3'b000;
			2'd1: extram2_blk = 3'b001;
			2'd2: extram2_blk = 3'b011;
			default: extram2_blk = 3'b111;
		endcase
	end

	assign menu_blk = {extram3_i, extram2_blk, extram1_i};

	// Masks just track their inputs
	always_ff @(posedge clk_sys) begin
		ext_q <= menu_blk | cart_blk_i;
		ro_q  <= cart_writable_i ? '0 : cart_blk_i;
	end

	//////////////////////////////////////////////////
	// Write merge
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_stb_q  <= 1'b0;
			rom_std_q <= rom_std_sel_i;
		end else begin
			wr_stb_q <= prg_wr_i.wr | img_wr_i.wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_wr_i.wr) begin
			wr_addr_q <= prg_wr_i.addr;
			wr_data_q <= prg_wr_i.data;
		end else if (img_wr_i.wr) begin
			wr_addr_q <= img_wr_i.addr;
			wr_data_q <= img_wr_i.data;
		end
	end

	assign mem_wr_o     = '{wr: wr_stb_q, addr: wr_addr_q, data: wr_data_q};
	assign ram_ext_o    = ext_q;
	assign ram_ext_ro_o = ro_q;
	assign rom_std_o    = rom_std_q;

	// One download type at a time, so the loaders never collide
	a_one_stream: assert property (@(posedge clk_sys) disable iff (reset)
		!(prg_wr_i.wr && img_wr_i.wr));

endmodule

`default_nettype wire

//--- source/prg_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module prg_loader (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire loader_pkg::dl_req_t dl_i,
	output loader_pkg::mem_wr_t      wr_o
);

	logic                  load_prg;
	logic                  load_rom;
	logic                  dl_q;
	logic                  dl_fall;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  data_wr;
	logic [15:0]           next_addr;
	logic [3:0]            seq_state;
	logic [2:0]            patch_step;
	logic [15:0]           patch_addr;
	logic [7:0]            patch_data;
	logic                  wr_stb_q;
	loader_pkg::mem_addr_u wr_addr_q;
	logic [7:0]            wr_data_q;

	assign load_prg = (dl_i.idx == `LDR_IDX_PRG);
	assign load_rom = (dl_i.idx == `LDR_IDX_ROM);
	assign dl_fall  = dl_q & ~dl_i.dl & load_prg;

	// Byte 0 and 1 of the file carry the load address
	assign hdr_lo  = dl_i.dl & load_prg & dl_i.wr & (dl_i.addr == 25'd0);
	assign hdr_hi  = dl_i.dl & load_prg & dl_i.wr & (dl_i.addr == 25'd1);
	assign data_wr = dl_i.dl & load_prg & dl_i.wr & (dl_i.addr > 25'd1)
		& (next_addr < `LDR_PRG_LIMIT);

	//////////////////////////////////////////////////
	// Pointer patch table
	//////////////////////////////////////////////////

	// Odd sequencer states emit one write each, eight in all
	assign patch_step = seq_state[3:1];

	always_comb begin
		if (patch_step < 3'd6) begin
			patch_addr = `LDR_PTR_BASE + {13'd0, patch_step};
		end else begin
			patch_addr = `LDR_PTR_END + {15'd0, patch_step[0]};
		end
		// Even steps carry the low byte
		patch_data = patch_step[0] ? next_addr[15:8] : next_addr[7:0];
	end

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q      <= 1'b0;
			seq_state <= 4'd0;
			wr_stb_q  <= 1'b0;
		end else begin
			dl_q     <= dl_i.dl;
			wr_stb_q <= data_wr | seq_state[0];
			if (seq_state != 4'd0) begin
				seq_state <= seq_state + 4'd1;
			end
			if (dl_fall) begin
				seq_state <= 4'd1;
			end
			// A fresh program or ROM download drops an unfinished patch
			if (dl_i.dl && (load_prg || load_rom)) begin
				seq_state <= 4'd0;
			end
		end
	end

	// Load address and write payload
	always_ff @(posedge clk_sys) begin
		if (hdr_lo) begin
			next_addr[7:0] <= dl_i.data;
		end
		if (hdr_hi) begin
			next_addr[15:8] <= dl_i.data;
		end
		if (data_wr) begin
			wr_addr_q.byte_addr <= next_addr;
			wr_data_q           <= dl_i.data;
			next_addr           <= next_addr + 16'd1;
		end else if (seq_state[0]) begin
			wr_addr_q.byte_addr <= patch_addr;
			wr_data_q           <= patch_data;
		end
	end

	assign wr_o = '{wr: wr_stb_q, addr: wr_addr_q, data: wr_data_q};

	// Program data and patch bytes all land below BASIC ROM space
	a_below_limit: assert property (@(posedge clk_sys) disable iff (reset)
		wr_o.wr |-> (wr_o.addr.byte_addr < `LDR_PRG_LIMIT));

	// End of a program download starts the patch with the first pointer byte
	a_patch_start: assert property (@(posedge clk_sys) disable iff (reset)
		dl_fall |=> ##1 (wr_o.wr && (wr_o.addr.byte_addr == `LDR_PTR_BASE)));

endmodule

`default_nettype wire

//--- source/vic_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_loader_top (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire loader_pkg::dl_req_t dl_i,
	input  wire logic                extram1_i,
	input  wire logic [1:0]          extram2_sel_i,
	input  wire logic                extram3_i,
	input  wire logic                cart_writable_i,
	input  wire logic                rom_std_sel_i,
	output loader_pkg::mem_wr_t      mem_wr_o,
	output loader_pkg::ram_blk_t     ram_ext_o,
	output loader_pkg::ram_blk_t     ram_ext_ro_o,
	output logic                     rom_std_o
);

	loader_pkg::mem_wr_t  prg_wr;
	loader_pkg::mem_wr_t  img_wr;
	loader_pkg::ram_blk_t cart_blk;

	//////////////////////////////////////////////////
	// Loaders
	//////////////////////////////////////////////////

	prg_loader prg_loader_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.wr_o    (prg_wr)
	);

	image_loader image_loader_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.wr_o       (img_wr),
		.cart_blk_o (cart_blk)
	);

	//////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////

	memory_map_ctrl memory_map_ctrl_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.prg_wr_i        (prg_wr),
		.img_wr_i        (img_wr),
		.cart_blk_i      (cart_blk),
		.extram1_i       (extram1_i),
		.extram2_sel_i   (extram2_sel_i),
		.extram3_i       (extram3_i),
		.cart_writable_i (cart_writable_i),
		.rom_std_sel_i   (rom_std_sel_i),
		.mem_wr_o        (mem_wr_o),
		.ram_ext_o       (ram_ext_o),
		.ram_ext_ro_o    (ram_ext_ro_o),
		.rom_std_o       (rom_std_o)
	);

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/loader_pkg.sv
source/prg_loader.sv
source/image_loader.sv
source/memory_map_ctrl.sv
source/vic_loader_top.sv
tb/tb_vic_loader.sv

//--- tb/tb_vic_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module tb_vic_loader;

	// Header plus payload bytes of the five download tests
	localparam int bytes_total     = 22 + 34 + 18 + 8 + 6;
	localparam int watchdog_cycles = 200 * bytes_total;
	localparam int wait_limit      = 64;

	bit                   clk_sys;
	logic                 reset;
	loader_pkg::dl_req_t  dl;
	logic                 extram1;
	logic [1:0]           extram2_sel;
	logic                 extram3;
	logic                 cart_writable;
	logic                 rom_std_sel;
	loader_pkg::mem_wr_t  mem_wr;
	loader_pkg::ram_blk_t ram_ext;
	loader_pkg::ram_blk_t ram_ext_ro;
	logic                 rom_std;

	logic [31:0]          lfsr;
	logic [7:0]           mem_model [logic [15:0]];
	loader_pkg::mem_wr_t  patch_q [$];
	logic [7:0]           exp_q [$];
	loader_pkg::ram_blk_t cart_seen;
	int                   data_wr_cnt;
	int                   data_base;
	int                   patch_base;
	int                   test_errors;
	int                   tests_run;
	int                   tests_failed;

	// BASIC pointer bytes in patch order, lo/hi pairs
	logic [15:0] patch_order [8] = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF};
	// Map bits 1-3 for each RAM 2 menu setting
	logic [2:0]  ram2_blocks [4] = '{3'b000, 3'b001, 3'b011, 3'b111};

	vic_loader_top vic_loader_top_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_i            (dl),
		.extram1_i       (extram1),
		.extram2_sel_i   (extram2_sel),
		.extram3_i       (extram3),
		.cart_writable_i (cart_writable),
		.rom_std_sel_i   (rom_std_sel),
		.mem_wr_o        (mem_wr),
		.ram_ext_o       (ram_ext),
		.ram_ext_ro_o    (ram_ext_ro),
		.rom_std_o       (rom_std)
	);

	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Memory model and watchdog
	//////////////////////////////////////////////////

	function automatic logic is_patch_addr(input logic [15:0] a);
		logic hit;
		hit = 1'b0;
		foreach (patch_order[k]) begin
			if (patch_order[k] == a) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// Sampled mid-cycle, away from the clock edge
	always @(negedge clk_sys) begin
		if (!reset && mem_wr.wr) begin
			mem_model[mem_wr.addr.byte_addr] = mem_wr.data;
			if (is_patch_addr(mem_wr.addr.byte_addr)) begin
				patch_q.push_back(mem_wr);
			end else begin
				data_wr_cnt = data_wr_cnt + 1;
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles and the run did not finish", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		test_errors++;
	endtask

	task automatic begin_test;
		test_errors = 0;
		data_base   = data_wr_cnt;
		patch_base  = patch_q.size();
		exp_q.delete();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errors);
		end
	endtask

	task automatic settle;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] idx_v, input logic [7:0] ext_v);
		@(posedge clk_sys);
		dl <= '{dl: 1'b1, idx: idx_v, wr: 1'b0, addr: '0, data: '0, ext: ext_v};
		@(posedge clk_sys);
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.addr <= addr;
		dl.data <= data;
		@(posedge clk_sys);
		dl.wr   <= 1'b0;
	endtask

	task automatic send_random(input int first, input int count);
		logic [7:0] b;
		int i;
		for (i = 0; i < count; i++) begin
			random_byte(b);
			exp_q.push_back(b);
			send_byte(25'(first + i), b);
		end
	endtask

	task automatic end_download;
		@(posedge clk_sys);
		dl.dl <= 1'b0;
	endtask

	task automatic wait_writes(input int data_n, input int patch_n);
		int cycles;
		cycles = 0;
		while ((data_wr_cnt - data_base < data_n || patch_q.size() - patch_base < patch_n)
			&& cycles < wait_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (cycles >= wait_limit) begin
			$display("Gave up waiting for memory writes after %0d cycles", wait_limit);
			test_errors++;
		end
		// Room for a stray write beyond the expected count
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic check_data(input logic [15:0] base, input int skip, input int n);
		logic [15:0] a;
		int i;
		if (data_wr_cnt - data_base != n) begin
			report_error($sformatf("%0d data writes, expected %0d", data_wr_cnt - data_base, n));
		end
		for (i = 0; i < n; i++) begin
			a = base + 16'(i);
			if (!mem_model.exists(a) || mem_model[a] != exp_q[skip + i]) begin
				report_error($sformatf("byte at %h is %h, expected %h", a, mem_model[a],
					exp_q[skip + i]));
			end
		end
	endtask

	task automatic check_patch(input logic [15:0] end_addr);
		loader_pkg::mem_wr_t w;
		logic [7:0]          exp_d;
		int                  i;
		if (patch_q.size() - patch_base != 8) begin
			report_error($sformatf("%0d patch writes, expected 8", patch_q.size() - patch_base));
		end else begin
			for (i = 0; i < 8; i++) begin
				w = patch_q[patch_base + i];
				exp_d = (i % 2 == 0) ? end_addr[7:0] : end_addr[15:8];
				if (w.addr.byte_addr != patch_order[i] || w.data != exp_d) begin
					report_error($sformatf("patch %0d wrote %h to %h, expected %h to %h", i,
						w.data, w.addr.byte_addr, exp_d, patch_order[i]));
				end
			end
		end
	endtask

	task automatic walk_ram2_menu;
		int s;
		for (s = 0; s < 4; s++) begin
			@(posedge clk_sys);
			extram1     <= 1'b1;
			extram2_sel <= 2'(s);
			settle();
			if (ram_ext != ({1'b0, ram2_blocks[s], 1'b1} | cart_seen)) begin
				report_error($sformatf("map %b with RAM 2 setting %0d", ram_ext, s));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_prg(input string name, input logic [15:0] load_addr, input int n,
		input int n_kept, input logic [15:0] end_addr);
		begin_test();
		start_download(`LDR_IDX_PRG, 8'h00);
		send_byte(25'd0, load_addr[7:0]);
		send_byte(25'd1, load_addr[15:8]);
		send_random(2, n);
		end_download();
		wait_writes(n_kept, 8);
		check_data(load_addr, 0, n_kept);
		if (mem_model.exists(end_addr)) begin
			report_error($sformatf("write at %h past the last data byte", end_addr));
		end
		check_patch(end_addr);
		finish_test(name);
	endtask

	task automatic test_crt;
		begin_test();
		start_download(`LDR_IDX_CRT, 8'h00);
		send_byte(25'd0, 8'h00);
		send_byte(25'd1, 8'hA0);
		send_random(2, 16);
		end_download();
		wait_writes(16, 0);
		check_data(16'hA000, 0, 16);
		cart_seen[4] = 1'b1;
		if (!ram_ext[4] || !ram_ext_ro[4]) begin
			report_error($sformatf("block $A000 map %b read-only %b", ram_ext, ram_ext_ro));
		end
		@(posedge clk_sys);
		cart_writable <= 1'b1;
		settle();
		if (ram_ext_ro[4]) begin
			report_error("read-only bit 4 still set with the cartridge writable");
		end
		@(posedge clk_sys);
		cart_writable <= 1'b0;
		finish_test("CRT load and blocks");
	endtask

	task automatic test_ct;
		begin_test();
		start_download(`LDR_IDX_CT, "6");
		send_random(0, 8);
		end_download();
		wait_writes(8, 0);
		check_data(16'h6000, 0, 8);
		cart_seen[3] = 1'b1;
		if (!ram_ext[3]) begin
			report_error($sformatf("map %b lacks block $6000", ram_ext));
		end
		finish_test("CT load");
	endtask

	task automatic test_rom;
		begin_test();
		start_download(`LDR_IDX_ROM, 8'h00);
		send_random('h3FFE, 6);
		end_download();
		wait_writes(4, 0);
		check_data(16'hC000, 2, 4);
		finish_test("ROM load");
	endtask

	task automatic test_map_reset;
		begin_test();
		walk_ram2_menu();
		@(posedge clk_sys);
		reset       <= 1'b1;
		rom_std_sel <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset       <= 1'b0;
		rom_std_sel <= 1'b0;
		cart_seen = '0;
		settle();
		if (ram_ext != {1'b0, ram2_blocks[3], 1'b1} || ram_ext_ro != '0) begin
			report_error($sformatf("after reset map %b read-only %b", ram_ext, ram_ext_ro));
		end
		if (rom_std != 1'b1 || mem_wr.wr) begin
			report_error($sformatf("after reset ROM select %b write %b", rom_std, mem_wr.wr));
		end
		// With the cartridge blocks gone every RAM 2 bit shows on its own
		walk_ram2_menu();
		finish_test("Expansion map and reset");
	endtask

	initial begin
		reset         <= 1'b1;
		dl            <= '0;
		extram1       <= 1'b0;
		extram2_sel   <= 2'd0;
		extram3       <= 1'b0;
		cart_writable <= 1'b0;
		rom_std_sel   <= 1'b0;
		lfsr      = 32'h1b9c;
		cart_seen = '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		test_prg("PRG load", 16'h1001, 20, 20, 16'h1015);
		test_prg("PRG limit", 16'h9FF0, 32, 16, 16'hA000);
		test_crt();
		test_ct();
		test_rom();
		test_map_reset();

		$display("Tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
